/* Makefile */
VERILATOR ?= verilator
TOP       ?= ddr3_read_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/ddr3_pkg.sv */
package ddr3_pkg;

  // DDR3 commands as {RAS#, CAS#, WE#}
  localparam logic [2:0] CMD_NOOP = 3'b111;
  localparam logic [2:0] CMD_ACTV = 3'b011;
  localparam logic [2:0] CMD_READ = 3'b101;
  localparam logic [2:0] CMD_PREC = 3'b010;
  localparam logic [2:0] CMD_REFR = 3'b001;

  // geometry of a 1Gb x16 part
  localparam int DDR_ROW_BITS  = 13;
  localparam int DDR_COL_BITS  = 10;
  localparam int DDR_BANK_BITS = 3;

  // BL8 drops the low three column bits, so 13 + 3 + 7 address bits remain
  localparam int BURST_COL_BITS = DDR_COL_BITS - 3;
  localparam int ADDR_BITS      = DDR_ROW_BITS + DDR_BANK_BITS + BURST_COL_BITS;

  // auto-precharge flag in the column address
  localparam int AP_BIT = 10;

  localparam int DATA_BITS   = 32;
  localparam int REQ_ID_BITS = 4;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // one command on the DDL bus
  typedef struct packed {
    logic                     req;
    logic [2:0]               cmd;
    logic [DDR_BANK_BITS-1:0] ba;
    logic [DDR_ROW_BITS-1:0]  adr;
  } ddr3_cmd_t;

  // AXI read address, burst-aligned
  typedef struct packed {
    logic [REQ_ID_BITS-1:0] id;
    logic [ADDR_BITS-1:0]   addr;
    logic [7:0]             len;
    logic [1:0]             burst;
  } axi_ar_t;

  // AXI read beat
  typedef struct packed {
    logic [DATA_BITS-1:0]   data;
    logic [REQ_ID_BITS-1:0] id;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

  // read beat from the DDL
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 last;
  } ddl_r_t;

  // address layout is {row, bank, col}
  function automatic logic [DDR_ROW_BITS-1:0] addr_row(input logic [ADDR_BITS-1:0] addr);
    return addr[ADDR_BITS-1 -: DDR_ROW_BITS];
  endfunction

  function automatic logic [DDR_BANK_BITS-1:0] addr_bank(input logic [ADDR_BITS-1:0] addr);
    return addr[BURST_COL_BITS +: DDR_BANK_BITS];
  endfunction

  // column address for READ, with the auto-precharge flag
  function automatic logic [DDR_ROW_BITS-1:0] col_adr(input logic [ADDR_BITS-1:0] addr,
                                                      input logic ap);
    logic [DDR_ROW_BITS-1:0] adr;
    adr = '0;
    adr[DDR_COL_BITS-1:0] = {addr[BURST_COL_BITS-1:0], 3'b000};
    adr[AP_BIT] = ap;
    return adr;
  endfunction

endpackage

/* ddr3_bypass/ddr3_bypass.sv */
`timescale 1ns/1ps
module ddr3_bypass #(
  parameter bit BYPASS_ENABLE = 1'b1
) (
  input  logic                 clock,
  input  logic                 reset,

  // fast read port
  input  ddr3_pkg::axi_ar_t    byp_ar_i,
  input  logic                 byp_arvalid_i,
  output logic                 byp_arready_o,

  output ddr3_pkg::axi_r_t     byp_r_o,
  output logic                 byp_rvalid_o,
  input  logic                 byp_rready_i,

  // controller side of the link
  input  ddr3_pkg::ddr3_cmd_t  ctl_cmd_i,
  output logic                 ctl_rdy_o,

  output ddr3_pkg::ddl_r_t     ctl_r_o,
  output logic                 ctl_rvalid_o,
  input  logic                 ctl_rready_i,

  // DDL side of the link
  output ddr3_pkg::ddr3_cmd_t  ddl_cmd_o,
  input  logic                 ddl_rdy_i,

  input  ddr3_pkg::ddl_r_t     ddl_r_i,
  input  logic                 ddl_rvalid_i,
  output logic                 ddl_rready_o
);

  typedef enum logic [2:0] {
    ST_IDLE, ST_PREC, ST_ACTV, ST_READ, ST_DATA, ST_REACT
  } state_t;

  state_t                               state;

  // row the controller believes is open
  logic                                 open_q;
  logic [ddr3_pkg::DDR_BANK_BITS-1:0]   open_ba;
  logic [ddr3_pkg::DDR_ROW_BITS-1:0]    open_row;
  logic                                 ctl_rd_pend;

  // captured fast request
  logic [ddr3_pkg::REQ_ID_BITS-1:0]     id_q;
  logic [ddr3_pkg::ADDR_BITS-1:0]       addr_q;
  logic                                 ap_q;
  logic                                 miss_q;

  logic                                 accept;
  logic                                 own;
  logic                                 ctl_take;
  logic                                 byp_take;
  logic                                 same_bank;
  logic                                 req_hit;
  logic                                 req_miss;
  logic                                 fast_out;
  logic                                 byp_last;
  ddr3_pkg::ddr3_cmd_t                  byp_cmd;

  // no output buffer, so rready must already be high when a read is taken
  // wait until the controller has no read data in flight
  assign byp_arready_o = BYPASS_ENABLE && state == ST_IDLE && byp_rready_i && !ctl_rd_pend;
  assign accept        = byp_arvalid_i & byp_arready_o;

  // the bus is ours from the accept cycle until the sequence ends
  assign own       = (state != ST_IDLE) | accept;
  assign ctl_rdy_o = ddl_rdy_i & ~own;
  assign ddl_cmd_o = own ? byp_cmd : ctl_cmd_i;

  assign ctl_take = ctl_cmd_i.req & ctl_rdy_o;
  assign byp_take = byp_cmd.req & ddl_rdy_i;

  // idle, hit or miss against the tracked row
  assign same_bank = open_q && ddr3_pkg::addr_bank(byp_ar_i.addr) == open_ba;
  assign req_hit   = same_bank && ddr3_pkg::addr_row(byp_ar_i.addr) == open_row;
  assign req_miss  = same_bank && ddr3_pkg::addr_row(byp_ar_i.addr) != open_row;

  // bypass command for the current step
  always_comb begin
    byp_cmd     = '0;
    byp_cmd.cmd = ddr3_pkg::CMD_NOOP;
    case (state)
      ST_PREC: begin
        byp_cmd.req = 1'b1;
        byp_cmd.cmd = ddr3_pkg::CMD_PREC;
        byp_cmd.ba  = ddr3_pkg::addr_bank(addr_q);
      end
      ST_ACTV: begin
        byp_cmd.req = 1'b1;
        byp_cmd.cmd = ddr3_pkg::CMD_ACTV;
        byp_cmd.ba  = ddr3_pkg::addr_bank(addr_q);
        byp_cmd.adr = ddr3_pkg::addr_row(addr_q);
      end
      ST_READ: begin
        byp_cmd.req = 1'b1;
        byp_cmd.cmd = ddr3_pkg::CMD_READ;
        byp_cmd.ba  = ddr3_pkg::addr_bank(addr_q);
        byp_cmd.adr = ddr3_pkg::col_adr(addr_q, ap_q);
      end
      ST_REACT: begin
        // restore the row the controller had open
        byp_cmd.req = 1'b1;
        byp_cmd.cmd = ddr3_pkg::CMD_ACTV;
        byp_cmd.ba  = open_ba;
        byp_cmd.adr = open_row;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state  <= ST_IDLE;
      ap_q   <= 1'b0;
      miss_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            // a hit leaves the row open, the others close it again
            ap_q   <= ~req_hit;
            miss_q <= req_miss;
            state  <= req_hit ? ST_READ : (req_miss ? ST_PREC : ST_ACTV);
          end
        end
        ST_PREC: if (byp_take) state <= ST_ACTV;
        ST_ACTV: if (byp_take) state <= ST_READ;
        ST_READ: if (byp_take) state <= ST_DATA;
        ST_DATA: begin
          if (byp_last) begin
            state <= miss_q ? ST_REACT : ST_IDLE;
          end
        end
        ST_REACT: if (byp_take) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      id_q   <= byp_ar_i.id;
      addr_q <= byp_ar_i.addr;
    end
  end

  // only controller commands move the tracker
  // the bypass always leaves the bank as it found it
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      open_q <= 1'b0;
    end else if (ctl_take) begin
      case (ctl_cmd_i.cmd)
        ddr3_pkg::CMD_ACTV: open_q <= 1'b1;
        ddr3_pkg::CMD_PREC: open_q <= 1'b0;
        ddr3_pkg::CMD_READ: if (ctl_cmd_i.adr[ddr3_pkg::AP_BIT]) open_q <= 1'b0;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ctl_take && ctl_cmd_i.cmd == ddr3_pkg::CMD_ACTV) begin
      open_ba  <= ctl_cmd_i.ba;
      open_row <= ctl_cmd_i.adr;
    end
  end

  // controller READ outstanding until its last beat is taken
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ctl_rd_pend <= 1'b0;
    end else if (ctl_take && ctl_cmd_i.cmd == ddr3_pkg::CMD_READ) begin
      ctl_rd_pend <= 1'b1;
    end else if (ctl_rvalid_o && ctl_rready_i && ddl_r_i.last) begin
      ctl_rd_pend <= 1'b0;
    end
  end

  // DDL beats belong to the fast port only in DATA
  assign fast_out = (state == ST_DATA);
  assign byp_last = byp_rvalid_o & byp_rready_i & ddl_r_i.last;

  assign byp_r_o = '{data: ddl_r_i.data, id: id_q, resp: ddr3_pkg::RESP_OKAY,
                     last: ddl_r_i.last};
  assign byp_rvalid_o = fast_out & ddl_rvalid_i;

  assign ctl_r_o      = ddl_r_i;
  assign ctl_rvalid_o = ~fast_out & ddl_rvalid_i;

  assign ddl_rready_o = fast_out ? byp_rready_i : ctl_rready_i;

endmodule

/* flist.f */
common/ddr3_pkg.sv
src/ddr3_read_ctrl.sv
ddr3_bypass/ddr3_bypass.sv
src/ddr3_read_top.sv
verification/ddr3_ddl_model.sv
verification/ddr3_read_asserts.sv
verification/ddr3_read_tb.sv

/* src/ddr3_read_ctrl.sv */
`timescale 1ns/1ps
module ddr3_read_ctrl #(
  parameter int DDR_FREQ_MHZ = 400
) (
  input  logic                 clock,
  input  logic                 reset,

  input  ddr3_pkg::axi_ar_t    slow_ar_i,
  input  logic                 slow_arvalid_i,
  output logic                 slow_arready_o,

  output ddr3_pkg::axi_r_t     slow_r_o,
  output logic                 slow_rvalid_o,
  input  logic                 slow_rready_i,

  output ddr3_pkg::ddr3_cmd_t  ctl_cmd_o,
  input  logic                 ctl_rdy_i,

  input  ddr3_pkg::ddl_r_t     ctl_r_i,
  input  logic                 ctl_rvalid_i,
  output logic                 ctl_rready_o
);

  // tRP and tRCD are 13.75 ns, rounded up to whole clocks
  localparam int TRP_CYCLES  = (DDR_FREQ_MHZ * 14 + 999) / 1000;
  localparam int TRCD_CYCLES = (DDR_FREQ_MHZ * 14 + 999) / 1000;

  typedef enum logic [2:0] {ST_IDLE, ST_PREC, ST_ACTV, ST_READ, ST_DATA} state_t;

  state_t                               state;
  logic [3:0]                           wait_q;
  logic                                 open_q;
  logic [ddr3_pkg::DDR_BANK_BITS-1:0]   open_ba;
  logic [ddr3_pkg::DDR_ROW_BITS-1:0]    open_row;
  ddr3_pkg::axi_ar_t                    ar_q;
  logic                                 accept;
  logic                                 hit;
  logic                                 cmd_take;
  logic                                 last_take;

  // one request at a time, so ready only while idle
  assign slow_arready_o = (state == ST_IDLE) & slow_arvalid_i;
  assign accept         = slow_arvalid_i & slow_arready_o;

  // same bank and row as the one left open
  assign hit = open_q && ddr3_pkg::addr_bank(slow_ar_i.addr) == open_ba &&
               ddr3_pkg::addr_row(slow_ar_i.addr) == open_row;

  assign cmd_take  = ctl_cmd_o.req & ctl_rdy_i;
  assign last_take = slow_rvalid_o & slow_rready_i & ctl_r_i.last;

  // command for the current state, held back while a timing wait runs
  always_comb begin
    ctl_cmd_o     = '0;
    ctl_cmd_o.cmd = ddr3_pkg::CMD_NOOP;
    case (state)
      ST_PREC: begin
        ctl_cmd_o.req = (wait_q == 4'd0);
        ctl_cmd_o.cmd = ddr3_pkg::CMD_PREC;
        ctl_cmd_o.ba  = open_ba;
      end
      ST_ACTV: begin
        ctl_cmd_o.req = (wait_q == 4'd0);
        ctl_cmd_o.cmd = ddr3_pkg::CMD_ACTV;
        ctl_cmd_o.ba  = ddr3_pkg::addr_bank(ar_q.addr);
        ctl_cmd_o.adr = ddr3_pkg::addr_row(ar_q.addr);
      end
      ST_READ: begin
        ctl_cmd_o.req = (wait_q == 4'd0);
        ctl_cmd_o.cmd = ddr3_pkg::CMD_READ;
        ctl_cmd_o.ba  = ddr3_pkg::addr_bank(ar_q.addr);
        // row stays open afterwards
        ctl_cmd_o.adr = ddr3_pkg::col_adr(ar_q.addr, 1'b0);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state  <= ST_IDLE;
      wait_q <= 4'd0;
      open_q <= 1'b0;
    end else begin
      if (wait_q != 4'd0) begin
        wait_q <= wait_q - 4'd1;
      end
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= hit ? ST_READ : (open_q ? ST_PREC : ST_ACTV);
          end
        end
        ST_PREC: begin
          if (cmd_take) begin
            state  <= ST_ACTV;
            wait_q <= 4'(TRP_CYCLES);
            open_q <= 1'b0;
          end
        end
        ST_ACTV: begin
          if (cmd_take) begin
            state  <= ST_READ;
            wait_q <= 4'(TRCD_CYCLES);
            open_q <= 1'b1;
          end
        end
        ST_READ: begin
          if (cmd_take) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (last_take) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // request and open-row payload
  always_ff @(posedge clock) begin
    if (accept) begin
      ar_q <= slow_ar_i;
    end
    if (state == ST_ACTV && cmd_take) begin
      open_ba  <= ddr3_pkg::addr_bank(ar_q.addr);
      open_row <= ddr3_pkg::addr_row(ar_q.addr);
    end
  end

  // beats pass straight through, tagged with the request id
  assign slow_r_o = '{data: ctl_r_i.data, id: ar_q.id, resp: ddr3_pkg::RESP_OKAY,
                      last: ctl_r_i.last};
  assign slow_rvalid_o = (state == ST_DATA) & ctl_rvalid_i;
  assign ctl_rready_o  = (state == ST_DATA) & slow_rready_i;

endmodule

/* src/ddr3_read_top.sv */
`timescale 1ns/1ps
module ddr3_read_top #(
  parameter int DDR_FREQ_MHZ  = 400,
  parameter bit BYPASS_ENABLE = 1'b1
) (
  input  logic                 clock,
  input  logic                 reset,

  // slow AXI read port
  input  ddr3_pkg::axi_ar_t    slow_ar_i,
  input  logic                 slow_arvalid_i,
  output logic                 slow_arready_o,
  output ddr3_pkg::axi_r_t     slow_r_o,
  output logic                 slow_rvalid_o,
  input  logic                 slow_rready_i,

  // fast AXI read port
  input  ddr3_pkg::axi_ar_t    byp_ar_i,
  input  logic                 byp_arvalid_i,
  output logic                 byp_arready_o,
  output ddr3_pkg::axi_r_t     byp_r_o,
  output logic                 byp_rvalid_o,
  input  logic                 byp_rready_i,

  // DDL link
  output ddr3_pkg::ddr3_cmd_t  ddl_cmd_o,
  input  logic                 ddl_rdy_i,
  input  ddr3_pkg::ddl_r_t     ddl_r_i,
  input  logic                 ddl_rvalid_i,
  output logic                 ddl_rready_o
);

  // controller to bypass
  ddr3_pkg::ddr3_cmd_t ctl_cmd;
  logic                ctl_rdy;
  ddr3_pkg::ddl_r_t    ctl_r;
  logic                ctl_rvalid;
  logic                ctl_rready;

  ddr3_read_ctrl #(
    .DDR_FREQ_MHZ(DDR_FREQ_MHZ)
  ) u_ctrl (
    .clock         (clock),
    .reset         (reset),
    .slow_ar_i     (slow_ar_i),
    .slow_arvalid_i(slow_arvalid_i),
    .slow_arready_o(slow_arready_o),
    .slow_r_o      (slow_r_o),
    .slow_rvalid_o (slow_rvalid_o),
    .slow_rready_i (slow_rready_i),
    .ctl_cmd_o     (ctl_cmd),
    .ctl_rdy_i     (ctl_rdy),
    .ctl_r_i       (ctl_r),
    .ctl_rvalid_i  (ctl_rvalid),
    .ctl_rready_o  (ctl_rready)
  );

  ddr3_bypass #(
    .BYPASS_ENABLE(BYPASS_ENABLE)
  ) u_bypass (
    .clock        (clock),
    .reset        (reset),
    .byp_ar_i     (byp_ar_i),
    .byp_arvalid_i(byp_arvalid_i),
    .byp_arready_o(byp_arready_o),
    .byp_r_o      (byp_r_o),
    .byp_rvalid_o (byp_rvalid_o),
    .byp_rready_i (byp_rready_i),
    .ctl_cmd_i    (ctl_cmd),
    .ctl_rdy_o    (ctl_rdy),
    .ctl_r_o      (ctl_r),
    .ctl_rvalid_o (ctl_rvalid),
    .ctl_rready_i (ctl_rready),
    .ddl_cmd_o    (ddl_cmd_o),
    .ddl_rdy_i    (ddl_rdy_i),
    .ddl_r_i      (ddl_r_i),
    .ddl_rvalid_i (ddl_rvalid_i),
    .ddl_rready_o (ddl_rready_o)
  );

endmodule

/* verification/ddr3_ddl_model.sv */
`timescale 1ns/1ps
module ddr3_ddl_model (
  input  logic                 clock,
  input  logic                 reset,
  input  ddr3_pkg::ddr3_cmd_t  cmd_i,
  output logic                 rdy_o,
  output ddr3_pkg::ddl_r_t     r_o,
  output logic                 rvalid_o,
  input  logic                 rready_i
);

  // every accepted command, in order
  ddr3_pkg::ddr3_cmd_t cmd_log [$];

  // row opened per bank by the last ACTIVATE
  logic [ddr3_pkg::DDR_ROW_BITS-1:0] row_q [0:7];
  logic [ddr3_pkg::ADDR_BITS-1:0]    base_q;
  logic                              busy_q;
  logic [2:0]                        delay_q;
  logic [1:0]                        beat_q;
  logic                              rdy_q;

  // one idle cycle after every accepted command
  assign rdy_o = rdy_q;

  // data word is the byte address of the beat
  assign r_o.data = {5'd0, base_q, 4'd0} + {28'd0, beat_q, 2'd0};
  assign r_o.last = (beat_q == 2'd3);

  always @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
      delay_q  <= 3'd0;
      beat_q   <= 2'd0;
      base_q   <= '0;
      rdy_q    <= 1'b1;
    end else begin
      rdy_q <= !(cmd_i.req && rdy_o);
      if (cmd_i.req && rdy_o) begin
        cmd_log.push_back(cmd_i);
        if (cmd_i.cmd == ddr3_pkg::CMD_ACTV) begin
          row_q[cmd_i.ba] <= cmd_i.adr;
        end
        if (cmd_i.cmd == ddr3_pkg::CMD_READ) begin
          base_q  <= {row_q[cmd_i.ba], cmd_i.ba, cmd_i.adr[9:3]};
          busy_q  <= 1'b1;
          delay_q <= 3'd3;
          beat_q  <= 2'd0;
        end
      end
      // first beat four cycles after READ
      if (busy_q && !rvalid_o) begin
        if (delay_q == 3'd0) begin
          rvalid_o <= 1'b1;
        end else begin
          delay_q <= delay_q - 3'd1;
        end
      end
      if (rvalid_o && rready_i) begin
        if (beat_q == 2'd3) begin
          rvalid_o <= 1'b0;
          busy_q   <= 1'b0;
        end else begin
          beat_q <= beat_q + 2'd1;
        end
      end
    end
  end

endmodule

/* verification/ddr3_read_asserts.sv */
`timescale 1ns/1ps
module ddr3_read_asserts (
  input logic                 clock,
  input logic                 reset,
  input ddr3_pkg::ddr3_cmd_t  ddl_cmd_o,
  input logic                 ddl_rdy_i,
  input logic                 byp_rready_i,
  input logic                 byp_rvalid_o,
  input ddr3_pkg::ddl_r_t     ctl_r_o,
  input logic                 ctl_rvalid_o,
  input logic                 ctl_rready_i
);

  // a stalled command holds still
  assert property (@(posedge clock) disable iff (reset)
    ddl_cmd_o.req && !ddl_rdy_i |=> $stable(ddl_cmd_o))
    else $error("ddl command changed while stalled");

  // fast port has no buffer
  assert property (@(posedge clock) disable iff (reset)
    byp_rvalid_o |-> byp_rready_i)
    else $error("fast beat without rready");

  // a controller beat held back stays on the controller port
  assert property (@(posedge clock) disable iff (reset)
    ctl_rvalid_o && !ctl_rready_i |=> ctl_rvalid_o && $stable(ctl_r_o))
    else $error("controller beat changed while stalled");

endmodule

bind ddr3_bypass ddr3_read_asserts u_asserts (
  .clock        (clock),
  .reset        (reset),
  .ddl_cmd_o    (ddl_cmd_o),
  .ddl_rdy_i    (ddl_rdy_i),
  .byp_rready_i (byp_rready_i),
  .byp_rvalid_o (byp_rvalid_o),
  .ctl_r_o      (ctl_r_o),
  .ctl_rvalid_o (ctl_rvalid_o),
  .ctl_rready_i (ctl_rready_i)
);

/* verification/ddr3_read_patterns.txt */
// port_conc_id_byteaddr_ncmd_cmd0_cmd1_cmd2_cmd3 (port 0 slow, 1 fast, f end)
// conc 1 runs the line together with the next one; commands are ddr3_cmd_t
0_0_1_00014820_2_b2005_d2010_00000_00000
1_0_3_0001d010_2_b4007_d4408_00000_00000
1_0_5_00014840_1_d2020_00000_00000_00000
1_0_6_00024800_4_a2000_b2009_d2400_b2005
0_0_2_00014860_1_d2030_00000_00000_00000
0_1_9_00009800_0_00000_00000_00000_00000
1_0_a_00006030_0_00000_00000_00000_00000
f_0_0_00000000_0_00000_00000_00000_00000

/* verification/ddr3_read_tb.sv */
`timescale 1ns/1ps
module ddr3_read_tb;

  localparam int TIMEOUT  = 1000;
  localparam int NUM_PATS = 16;
  localparam logic [31:0] SEED = 32'h36bf_474f;

  logic                clock;
  logic                reset;
  ddr3_pkg::axi_ar_t   slow_ar;
  logic                slow_arvalid;
  logic                slow_arready;
  ddr3_pkg::axi_r_t    slow_r;
  logic                slow_rvalid;
  logic                slow_rready;
  ddr3_pkg::axi_ar_t   byp_ar;
  logic                byp_arvalid;
  logic                byp_arready;
  ddr3_pkg::axi_r_t    byp_r;
  logic                byp_rvalid;
  logic                byp_rready;
  ddr3_pkg::ddr3_cmd_t ddl_cmd;
  logic                ddl_rdy;
  ddr3_pkg::ddl_r_t    ddl_r;
  logic                ddl_rvalid;
  logic                ddl_rready;

  logic [127:0] pats [0:NUM_PATS-1];
  int           err_cnt;
  int           test_err;
  int           test_cnt;
  int           check_cnt;
  bit           timed_out;
  bit           rand_gaps;

  ddr3_read_top #(.DDR_FREQ_MHZ(400), .BYPASS_ENABLE(1'b1)) dut (
    .clock(clock), .reset(reset),
    .slow_ar_i(slow_ar), .slow_arvalid_i(slow_arvalid), .slow_arready_o(slow_arready),
    .slow_r_o(slow_r), .slow_rvalid_o(slow_rvalid), .slow_rready_i(slow_rready),
    .byp_ar_i(byp_ar), .byp_arvalid_i(byp_arvalid), .byp_arready_o(byp_arready),
    .byp_r_o(byp_r), .byp_rvalid_o(byp_rvalid), .byp_rready_i(byp_rready),
    .ddl_cmd_o(ddl_cmd), .ddl_rdy_i(ddl_rdy),
    .ddl_r_i(ddl_r), .ddl_rvalid_i(ddl_rvalid), .ddl_rready_o(ddl_rready)
  );

  ddr3_ddl_model u_ddl (
    .clock(clock), .reset(reset), .cmd_i(ddl_cmd), .rdy_o(ddl_rdy),
    .r_o(ddl_r), .rvalid_o(ddl_rvalid), .rready_i(ddl_rready)
  );

  always #2 clock = ~clock;

  // random gaps in slow back-pressure, from a fixed seed
  initial begin
    slow_rready = 1'b1;
    void'($urandom(SEED));
    forever begin
      @(posedge clock);
      slow_rready <= rand_gaps ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  task automatic check_beat(input string name, input ddr3_pkg::axi_r_t got,
                            input ddr3_pkg::axi_r_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_cmd(input string name, input ddr3_pkg::ddr3_cmd_t got,
                           input ddr3_pkg::ddr3_cmd_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      test_err++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    test_err++;
    timed_out = 1'b1;
  endtask

  // expected beat from the address rule
  function automatic ddr3_pkg::axi_r_t expect_beat(input logic [3:0] id,
                                                  input logic [31:0] byte_addr, input int i);
    ddr3_pkg::axi_r_t b;
    b.data = byte_addr + 32'(i * 4);
    b.id   = id;
    b.resp = ddr3_pkg::RESP_OKAY;
    b.last = (i == 3);
    return b;
  endfunction

  task automatic slow_read(input logic [3:0] id, input logic [31:0] byte_addr);
    int t;
    @(posedge clock);
    slow_ar      <= '{id: id, addr: byte_addr[26:4], len: 8'd3, burst: 2'b01};
    slow_arvalid <= 1'b1;
    t = 0;
    do begin
      @(posedge clock);
      t++;
    end while (!slow_arready && t < TIMEOUT);
    slow_arvalid <= 1'b0;
    if (t >= TIMEOUT) begin
      report_timeout("slow_arready_o");
      return;
    end
    for (int i = 0; i < 4; i++) begin
      t = 0;
      do begin
        @(posedge clock);
        t++;
      end while (!(slow_rvalid && slow_rready) && t < TIMEOUT);
      if (t >= TIMEOUT) begin
        report_timeout("slow_rvalid_o");
        return;
      end
      check_beat("slow_r_o", slow_r, expect_beat(id, byte_addr, i));
    end
  endtask

  task automatic fast_read(input logic [3:0] id, input logic [31:0] byte_addr);
    int t;
    @(posedge clock);
    byp_ar      <= '{id: id, addr: byte_addr[26:4], len: 8'd3, burst: 2'b01};
    byp_arvalid <= 1'b1;
    byp_rready  <= 1'b1;
    t = 0;
    do begin
      @(posedge clock);
      t++;
    end while (!byp_arready && t < TIMEOUT);
    byp_arvalid <= 1'b0;
    if (t >= TIMEOUT) begin
      report_timeout("byp_arready_o");
      return;
    end
    for (int i = 0; i < 4; i++) begin
      t = 0;
      do begin
        @(posedge clock);
        t++;
      end while (!byp_rvalid && t < TIMEOUT);
      if (t >= TIMEOUT) begin
        report_timeout("byp_rvalid_o");
        return;
      end
      check_beat("byp_r_o", byp_r, expect_beat(id, byte_addr, i));
    end
    byp_rready <= 1'b0;
  endtask

  task automatic run_pattern(input logic [127:0] p);
    if (p[127:124] == 4'd0) slow_read(p[119:116], p[115:84]);
    else fast_read(p[119:116], p[115:84]);
  endtask

  // commands logged since start must match the pattern line
  task automatic check_cmd_log(input int start, input logic [127:0] p);
    int n;
    int t;
    n = int'(p[83:80]);
    if (n == 0) return;
    t = 0;
    while (u_ddl.cmd_log.size() < start + n && t < TIMEOUT) begin
      @(posedge clock);
      t++;
    end
    if (t >= TIMEOUT) begin
      report_timeout("DDL commands");
      return;
    end
    @(posedge clock);
    if (u_ddl.cmd_log.size() != start + n) begin
      $display("wrong number of DDL commands, %0d instead of %0d",
               u_ddl.cmd_log.size() - start, n);
      test_err++;
    end
    for (int i = 0; i < n; i++) begin
      check_cmd("ddl_cmd_o", u_ddl.cmd_log[start+i], ddr3_pkg::ddr3_cmd_t'(p[79-20*i -: 20]));
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, test_err);
    err_cnt += test_err;
    test_err = 0;
  endtask

  initial begin
    int idx;
    int start;
    clock        = 1'b0;
    reset        = 1'b1;
    slow_ar      = '0;
    slow_arvalid = 1'b0;
    byp_ar       = '0;
    byp_arvalid  = 1'b0;
    byp_rready   = 1'b0;
    rand_gaps    = 1'b0;
    err_cnt = 0;
    test_err = 0;
    test_cnt = 0;
    check_cnt = 0;
    timed_out = 1'b0;
    for (int i = 0; i < NUM_PATS; i++) pats[i] = {4'hf, 124'd0};
    $readmemh("verification/ddr3_read_patterns.txt", pats);

    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    @(posedge clock);
    check_flag("slow_arready_o", slow_arready, 1'b0);
    check_flag("byp_arready_o", byp_arready, 1'b0);
    check_flag("slow_rvalid_o", slow_rvalid, 1'b0);
    check_flag("byp_rvalid_o", byp_rvalid, 1'b0);
    check_flag("ddl_rready_o", ddl_rready, 1'b0);
    if (u_ddl.cmd_log.size() != 0) begin
      $display("DDL commands were logged during reset");
      test_err++;
    end
    end_test("reset");
    rand_gaps <= 1'b1;

    idx = 0;
    while (idx < NUM_PATS && pats[idx][127:124] != 4'hf && !timed_out) begin
      start = u_ddl.cmd_log.size();
      if (pats[idx][123:120] != 4'd0 && idx + 1 < NUM_PATS) begin
        fork
          run_pattern(pats[idx]);
          run_pattern(pats[idx+1]);
        join
        end_test("slow and fast together");
        idx += 2;
      end else begin
        run_pattern(pats[idx]);
        check_cmd_log(start, pats[idx]);
        end_test(pats[idx][127:124] == 4'd0 ? "slow read" : "fast read");
        idx++;
      end
    end

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
